// ==== rtl/comefa_pkg.sv ====
////////////////////////////////////////
// shared widths, opcodes and packed
// structs of the CiM CFU command front end
////////////////////////////////////////

package comefa_pkg;

  ////////////////////////////////////////
  // CRAM geometry
  ////////////////////////////////////////

  // word address inside one bank
  localparam int CRAM_AWIDTH = 9;
  localparam int CRAM_DEPTH = 512;
  // bank field above the word address, up to four banks
  localparam int BANK_BITS = 2;

  // one CRAM word, 32 data bits plus 8 extra bits in transposed order
  typedef logic [39:0] cram_word_t;

  // one instruction RAM word
  typedef logic [31:0] instr_word_t;

  // bank in the top bits, word address below
  typedef logic [BANK_BITS+CRAM_AWIDTH-1:0] cram_full_addr_t;

  ////////////////////////////////////////
  // command decode
  ////////////////////////////////////////

  // funct3 values of the supported ops
  typedef enum logic [2:0] {
    OP_BYTE_ADD    = 3'd0,
    OP_INSTR_WRITE = 3'd3,
    OP_INSTR_READ  = 3'd4,
    OP_CRAM_WRITE  = 3'd5,
    OP_CRAM_READ   = 3'd6
  } cfu_op_e;

  // cpu command, function_id split as funct7 over funct3
  // funct3 stays plain so unsupported codes pass through
  typedef struct packed {
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic [31:0] inputs_0;
    logic [31:0] inputs_1;
  } cfu_cmd_t;

  // op5 request from the command fsm
  typedef struct packed {
    logic            valid;
    logic            use_pointer;
    cram_full_addr_t addr;
    cram_word_t      data;
  } cram_wr_req_t;

  // one bank write, broadcast to all banks
  typedef struct packed {
    logic                   we;
    logic [BANK_BITS-1:0]   bank;
    logic [CRAM_AWIDTH-1:0] addr;
    cram_word_t             data;
  } cram_wr_t;

endpackage

// ==== rtl/word_ram.sv ====
////////////////////////////////////////
// simple dual port synchronous RAM with
// a type parameterized word
////////////////////////////////////////

`timescale 1ns/1ps

module word_ram #(
  parameter int  DEPTH  = 512,
  parameter type word_t = logic [31:0]
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  word_t                    wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output word_t                    rd_data
);

  // storage array
  word_t mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, one cycle latency
  // a read of the word being written returns the old contents
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // writes stay inside the array for any DEPTH
  // (DEPTH need not be a power of two)
  a_wr_addr_in_range: assert property (
    @(posedge clk) we |-> (int'(wr_addr) < DEPTH)
  );

endmodule

// ==== rtl/cram_write_sequencer.sv ====
////////////////////////////////////////
// op5 write path: address pointer and
// bank write decode for the CRAM array
////////////////////////////////////////

`timescale 1ns/1ps

module cram_write_sequencer #(
  parameter int NUM_BANKS = 4
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  comefa_pkg::cram_wr_req_t req,
  output comefa_pkg::cram_wr_t     wr
);

  // next auto-increment address, full bank plus word
  comefa_pkg::cram_full_addr_t wr_ptr;
  // address the current request goes to
  comefa_pkg::cram_full_addr_t target;

  // registered bank write
  comefa_pkg::cram_wr_t wr_q;

  // explicit address or the running pointer
  assign target = req.use_pointer ? wr_ptr : req.addr;

  ////////////////////////////////////////
  // pointer and write register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr  <= '0;
      wr_q.we <= 1'b0;
    end else begin
      // one write per request, one cycle after the fsm registers it
      wr_q.we <= req.valid;
      if (req.valid) begin
        // full width increment, word 511 rolls into the next bank
        wr_ptr    <= target + comefa_pkg::cram_full_addr_t'(1);
        wr_q.bank <= target[comefa_pkg::CRAM_AWIDTH +: comefa_pkg::BANK_BITS];
        wr_q.addr <= target[comefa_pkg::CRAM_AWIDTH-1:0];
        wr_q.data <= req.data;
      end
    end
  end

  // broadcast to all banks, each bank decodes its own enable
  assign wr = wr_q;

  // cpu addresses and pointer runs must stay inside the fitted banks
  a_bank_in_range: assert property (
    @(posedge clk) disable iff (!resetn)
    wr.we |-> (int'(wr.bank) < NUM_BANKS)
  );

endmodule

// ==== rtl/cram_read_select.sv ====
////////////////////////////////////////
// op6 read path: bank select, bit reversal
// and output register of CRAM read data
////////////////////////////////////////

`timescale 1ns/1ps

module cram_read_select #(
  parameter int NUM_BANKS = 4
) (
  input  logic                            clk,
  input  logic [comefa_pkg::BANK_BITS-1:0] rd_bank,
  input  comefa_pkg::cram_word_t          bank_data [NUM_BANKS],
  output logic [31:0]                     rd_word
);

  localparam int WORD_BITS = $bits(comefa_pkg::cram_word_t);

  // bank field delayed to match the RAM read latency
  logic [comefa_pkg::BANK_BITS-1:0] bank_q;
  // selected bank word, still in stored bit order
  comefa_pkg::cram_word_t sel_word;
  // word back in cpu bit order
  comefa_pkg::cram_word_t rev_word;

  always_ff @(posedge clk) begin
    bank_q <= rd_bank;
  end

  ////////////////////////////////////////
  // select and un-transpose
  ////////////////////////////////////////

  // unfitted banks read as zero
  always_comb begin
    sel_word = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (int'(bank_q) == b) begin
        sel_word = bank_data[b];
      end
    end
  end

  // reverse all 40 bits, inputs_0 lands in the low 32
  always_comb begin
    for (int i = 0; i < WORD_BITS; i++) begin
      rev_word[i] = sel_word[WORD_BITS-1-i];
    end
  end

  // extra register stage, top 8 bits dropped
  always_ff @(posedge clk) begin
    rd_word <= rev_word[31:0];
  end

endmodule

// ==== rtl/cfu_cmd_fsm.sv ====
////////////////////////////////////////
// CFU command fsm: command capture,
// latency sequencing, byte add and
// response mux
////////////////////////////////////////

`timescale 1ns/1ps

module cfu_cmd_fsm (
  input  logic                                  clk,
  input  logic                                  resetn,
  input  logic                                  cmd_valid,
  input  comefa_pkg::cfu_cmd_t                  cmd,
  output logic                                  cmd_ready,
  output logic                                  rsp_valid,
  output logic [31:0]                           rsp_data,
  output comefa_pkg::cram_wr_req_t              cram_req,
  output comefa_pkg::cram_full_addr_t           read_addr,
  output logic                                  instr_we,
  output logic [comefa_pkg::CRAM_AWIDTH-1:0]    instr_addr,
  output comefa_pkg::instr_word_t               instr_wdata,
  input  comefa_pkg::instr_word_t               instr_rdata,
  input  logic [31:0]                           cram_rd_word
);

  // read ops pass through read_wait for the extra RAM stage
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ_WAIT,
    ST_WAIT,
    ST_RESPOND
  } state_e;

  state_e state;

  // command held for the whole transaction
  comefa_pkg::cfu_cmd_t cmd_q;

  logic accept;
  logic is_read;
  comefa_pkg::cram_word_t packed_word;
  logic [8:0] byte_sum;
  logic [31:0] rsp_mux;

  assign accept = cmd_valid && cmd_ready;

  // op4 and op6 take one more cycle
  assign is_read = (cmd.funct3 == comefa_pkg::OP_INSTR_READ) ||
                   (cmd.funct3 == comefa_pkg::OP_CRAM_READ);

  ////////////////////////////////////////
  // handshake and latency fsm
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= ST_IDLE;
      cmd_ready <= 1'b1;
      rsp_valid <= 1'b0;
    end else begin
      // rsp_ready is not looked at, response is a single pulse
      rsp_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            cmd_ready <= 1'b0;
            state     <= is_read ? ST_READ_WAIT : ST_WAIT;
          end
        end
        ST_READ_WAIT: begin
          state <= ST_WAIT;
        end
        ST_WAIT: begin
          state <= ST_RESPOND;
        end
        ST_RESPOND: begin
          rsp_valid <= 1'b1;
          cmd_ready <= 1'b1;
          state     <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // capture on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  ////////////////////////////////////////
  // op5 request
  ////////////////////////////////////////

  // transpose into CRAM bit order
  // inputs_0 reversed on top, low byte of inputs_1 reversed below
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      packed_word[8+i] = cmd.inputs_0[31-i];
    end
    for (int i = 0; i < 8; i++) begin
      packed_word[i] = cmd.inputs_1[7-i];
    end
  end

  // registered at acceptance, valid for one cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cram_req.valid <= 1'b0;
    end else begin
      cram_req.valid <= accept && (cmd.funct3 == comefa_pkg::OP_CRAM_WRITE);
      if (accept) begin
        // funct7 = 1 continues at the sequencer pointer
        cram_req.use_pointer <= (cmd.funct7 == 7'd1);
        cram_req.addr        <= cmd.inputs_1[18:8];
        cram_req.data        <= packed_word;
      end
    end
  end

  // op6 full read address, bank field plus word
  assign read_addr = cmd_q.inputs_0[10:0];

  ////////////////////////////////////////
  // instruction RAM, ops 3 and 4
  ////////////////////////////////////////

  // write lands one cycle after acceptance
  assign instr_we    = (state == ST_WAIT) && (cmd_q.funct3 == comefa_pkg::OP_INSTR_WRITE);
  assign instr_addr  = cmd_q.inputs_0[comefa_pkg::CRAM_AWIDTH-1:0];
  assign instr_wdata = cmd_q.inputs_1;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // op0, unsigned sum of the low bytes
  assign byte_sum = {1'b0, cmd_q.inputs_0[7:0]} + {1'b0, cmd_q.inputs_1[7:0]};

  always_comb begin
    case (cmd_q.funct3)
      comefa_pkg::OP_BYTE_ADD:    rsp_mux = {23'd0, byte_sum};
      comefa_pkg::OP_INSTR_WRITE: rsp_mux = '1;
      comefa_pkg::OP_INSTR_READ:  rsp_mux = instr_rdata;
      comefa_pkg::OP_CRAM_WRITE:  rsp_mux = '1;
      comefa_pkg::OP_CRAM_READ:   rsp_mux = cram_rd_word;
      // unsupported ops answer zero
      default:                    rsp_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == ST_RESPOND) begin
      rsp_data <= rsp_mux;
    end
  end

  // idle never leaves the cpu without a handshake
  a_idle_handshake: assert property (
    @(posedge clk) disable iff (!resetn)
    (state == ST_IDLE) |-> (cmd_ready || rsp_valid)
  );

endmodule

// ==== rtl/comefa_cfu.sv ====
////////////////////////////////////////
// CiM CFU top level: command fsm,
// instruction RAM and CRAM bank array
////////////////////////////////////////

`timescale 1ns/1ps

module comefa_cfu #(
  parameter int NUM_BANKS = 4
) (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 cmd_valid,
  input  comefa_pkg::cfu_cmd_t cmd,
  // no back-pressure on the response side
  input  logic                 rsp_ready,
  output logic                 cmd_ready,
  output logic                 rsp_valid,
  output logic [31:0]          rsp_data
);

  comefa_pkg::cram_wr_req_t    cram_req;
  comefa_pkg::cram_wr_t        cram_wr;
  comefa_pkg::cram_full_addr_t read_addr;
  comefa_pkg::cram_word_t      bank_rdata [NUM_BANKS];
  logic [31:0]                 cram_rd_word;

  logic                                 instr_we;
  logic [comefa_pkg::CRAM_AWIDTH-1:0]   instr_addr;
  comefa_pkg::instr_word_t              instr_wdata;
  comefa_pkg::instr_word_t              instr_rdata;

  ////////////////////////////////////////
  // command front end
  ////////////////////////////////////////

  cfu_cmd_fsm u_cmd_fsm (
    .clk          (clk),
    .resetn       (resetn),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .cmd_ready    (cmd_ready),
    .rsp_valid    (rsp_valid),
    .rsp_data     (rsp_data),
    .cram_req     (cram_req),
    .read_addr    (read_addr),
    .instr_we     (instr_we),
    .instr_addr   (instr_addr),
    .instr_wdata  (instr_wdata),
    .instr_rdata  (instr_rdata),
    .cram_rd_word (cram_rd_word)
  );

  // 512 x 32 instruction store, one address for both ports
  word_ram #(
    .DEPTH  (comefa_pkg::CRAM_DEPTH),
    .word_t (comefa_pkg::instr_word_t)
  ) u_instr_ram (
    .clk     (clk),
    .we      (instr_we),
    .wr_addr (instr_addr),
    .wr_data (instr_wdata),
    .rd_addr (instr_addr),
    .rd_data (instr_rdata)
  );

  ////////////////////////////////////////
  // CRAM bank array
  ////////////////////////////////////////

  cram_write_sequencer #(
    .NUM_BANKS (NUM_BANKS)
  ) u_wr_seq (
    .clk    (clk),
    .resetn (resetn),
    .req    (cram_req),
    .wr     (cram_wr)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    // enable from the bank index of this position
    logic bank_we;

    assign bank_we = cram_wr.we && (int'(cram_wr.bank) == b);

    // all banks share write data and read address
    word_ram #(
      .DEPTH  (comefa_pkg::CRAM_DEPTH),
      .word_t (comefa_pkg::cram_word_t)
    ) u_cram (
      .clk     (clk),
      .we      (bank_we),
      .wr_addr (cram_wr.addr),
      .wr_data (cram_wr.data),
      .rd_addr (read_addr[comefa_pkg::CRAM_AWIDTH-1:0]),
      .rd_data (bank_rdata[b])
    );
  end

  cram_read_select #(
    .NUM_BANKS (NUM_BANKS)
  ) u_rd_sel (
    .clk       (clk),
    .rd_bank   (read_addr[comefa_pkg::CRAM_AWIDTH +: comefa_pkg::BANK_BITS]),
    .bank_data (bank_rdata),
    .rd_word   (cram_rd_word)
  );

endmodule

// ==== tests/tb_comefa_cfu.sv ====
////////////////////////////////////////
// testbench for the CiM CFU front end:
// clock, reset, stimulus table, checks
// and cycle watchdog
////////////////////////////////////////

`timescale 1ns/1ps

module tb_comefa_cfu;

  localparam int CLK_HALF  = 5;
  localparam int LAT_WRITE = 2;
  localparam int LAT_READ  = 3;

  // one table row, command plus expected response
  typedef struct packed {
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] in0;
    logic [31:0] in1;
    logic [31:0] exp_data;
    logic [2:0]  exp_lat;
  } entry_t;

  logic                 clk;
  logic                 resetn;
  logic                 cmd_valid;
  comefa_pkg::cfu_cmd_t cmd;
  logic                 rsp_ready;
  logic                 cmd_ready;
  logic                 rsp_valid;
  logic [31:0]          rsp_data;

  entry_t stim [$];
  int     errors;
  int     checks;
  int     cycles;
  int     cycle_limit;

  comefa_cfu #(
    .NUM_BANKS (4)
  ) u_comefa_cfu (
    .clk       (clk),
    .resetn    (resetn),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rsp_ready (rsp_ready),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic entry_t make_entry(input logic [2:0] op, input logic [6:0] f7,
                                        input logic [31:0] in0, input logic [31:0] in1,
                                        input logic [31:0] exp_data, input int lat);
    entry_t e;
    e.funct3   = op;
    e.funct7   = f7;
    e.in0      = in0;
    e.in1      = in1;
    e.exp_data = exp_data;
    e.exp_lat  = 3'(lat);
    return e;
  endfunction

  // commands in issue order with their expected responses
  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [8:0]  base;
    logic [8:0]  iaddr [4];
    logic [31:0] idata [4];
    logic [10:0] caddr [4];
    logic [31:0] cdata [4];
    logic [31:0] seq_data [4];
    logic [2:0]  bad_ops [3];
    // byte add, zero extended sum of the low bytes
    for (int i = 0; i < 4; i++) begin
      a = $urandom();
      b = $urandom();
      stim.push_back(make_entry(comefa_pkg::OP_BYTE_ADD, 7'($urandom()), a, b,
                                32'(a[7:0]) + 32'(b[7:0]), LAT_WRITE));
    end
    // instruction RAM, distinct addresses written then read back
    base = 9'($urandom());
    for (int i = 0; i < 4; i++) begin
      iaddr[i] = base + 9'(i * 37);
      idata[i] = $urandom();
      a = $urandom();
      a[8:0] = iaddr[i];
      stim.push_back(make_entry(comefa_pkg::OP_INSTR_WRITE, 7'd0, a, idata[i],
                                32'hffff_ffff, LAT_WRITE));
    end
    for (int i = 0; i < 4; i++) begin
      a = $urandom();
      a[8:0] = iaddr[i];
      stim.push_back(make_entry(comefa_pkg::OP_INSTR_READ, 7'd0, a, $urandom(),
                                idata[i], LAT_READ));
    end
    // one explicit CRAM write per bank at a random word
    for (int i = 0; i < 4; i++) begin
      caddr[i] = {2'(i), 9'($urandom())};
      cdata[i] = $urandom();
      b = $urandom();
      b[18:8] = caddr[i];
      stim.push_back(make_entry(comefa_pkg::OP_CRAM_WRITE, 7'd0, cdata[i], b,
                                32'hffff_ffff, LAT_WRITE));
    end
    for (int i = 0; i < 4; i++) begin
      a = $urandom();
      a[10:0] = caddr[i];
      stim.push_back(make_entry(comefa_pkg::OP_CRAM_READ, 7'd0, a, $urandom(),
                                cdata[i], LAT_READ));
    end
    // pointer run from bank 0 word 510 across into bank 1
    // address field of the pointer writes is random and must be ignored
    for (int i = 0; i < 4; i++) begin
      seq_data[i] = $urandom();
      b = $urandom();
      if (i == 0) begin
        b[18:8] = 11'd510;
      end
      stim.push_back(make_entry(comefa_pkg::OP_CRAM_WRITE, (i == 0) ? 7'd0 : 7'd1,
                                seq_data[i], b, 32'hffff_ffff, LAT_WRITE));
    end
    for (int i = 0; i < 4; i++) begin
      a = $urandom();
      a[10:0] = 11'd510 + 11'(i);
      stim.push_back(make_entry(comefa_pkg::OP_CRAM_READ, 7'd0, a, $urandom(),
                                seq_data[i], LAT_READ));
    end
    // unsupported codes answer zero
    bad_ops = '{3'd1, 3'd2, 3'd7};
    for (int i = 0; i < 3; i++) begin
      stim.push_back(make_entry(bad_ops[i], 7'($urandom()), $urandom(), $urandom(),
                                32'd0, LAT_WRITE));
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_entry(input entry_t e, input int idx);
    int lat;
    lat = 0;
    check_value(32'(cmd_ready), 32'd1, $sformatf("entry %0d cmd_ready before issue", idx));
    cmd.funct7   = e.funct7;
    cmd.funct3   = e.funct3;
    cmd.inputs_0 = e.in0;
    cmd.inputs_1 = e.in1;
    cmd_valid    = 1'b1;
    // acceptance edge
    @(posedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
    // count edges after acceptance until the response pulse
    while (rsp_valid !== 1'b1) begin
      check_value(32'(cmd_ready), 32'd0, $sformatf("entry %0d cmd_ready while busy", idx));
      lat++;
      @(negedge clk);
    end
    check_value(32'(lat), 32'(e.exp_lat), $sformatf("entry %0d latency", idx));
    check_value(rsp_data, e.exp_data, $sformatf("entry %0d op %0d rsp_data", idx, e.funct3));
    check_value(32'(cmd_ready), 32'd1, $sformatf("entry %0d cmd_ready with rsp", idx));
    @(negedge clk);
    // single cycle pulse
    check_value(32'(rsp_valid), 32'd0, $sformatf("entry %0d rsp_valid pulse width", idx));
  endtask

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still going after %0d cycles", cycles);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'had18));
    resetn    = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    rsp_ready = 1'b1;
    errors    = 0;
    checks    = 0;
    build_table();
    // eight cycles per entry covers issue, latency and tail
    cycle_limit = stim.size() * 8 + 50;
    repeat (3) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    check_value(32'(cmd_ready), 32'd1, "cmd_ready after reset");
    check_value(32'(rsp_valid), 32'd0, "rsp_valid after reset");
    for (int i = 0; i < stim.size(); i++) begin
      run_entry(stim[i], i);
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/comefa_pkg.sv
rtl/word_ram.sv
rtl/cram_write_sequencer.sv
rtl/cram_read_select.sv
rtl/cfu_cmd_fsm.sv
rtl/comefa_cfu.sv
tests/tb_comefa_cfu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the comefa_cfu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_comefa_cfu --Mdir "$OBJ" -f vlog.f; then
  echo "verilator build failed"
  exit 1
fi

if ! "./$OBJ/Vtb_comefa_cfu" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "result: FAIL"
  exit 1
fi

echo "result: PASS"
exit 0
